//--- hdl/lspcPkg.sv
/*
 * Shared definitions for the line-sprite controller registers
 * Register offsets, VRAM geometry
 * Wishbone request and response structs
 * VRAM command struct, timer control struct
 */
package lspcPkg;

	// Register word offsets on the CPU bus
	localparam logic [2:0] REG_VRAMADDR  = 3'd0;
	localparam logic [2:0] REG_VRAMRW    = 3'd1;
	localparam logic [2:0] REG_VRAMMOD   = 3'd2;
	localparam logic [2:0] REG_LSPCMODE  = 3'd3;
	localparam logic [2:0] REG_TIMERHIGH = 3'd4;
	localparam logic [2:0] REG_TIMERLOW  = 3'd5;
	localparam logic [2:0] REG_IRQACK    = 3'd6;
	localparam logic [2:0] REG_TIMERSTOP = 3'd7;

	// Single VRAM, low address bits only
	localparam int VRAM_AW    = 11;
	localparam int VRAM_DEPTH = 2048;

	// Master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [15:0] dat;
	} wbReq;

	// Slave to master
	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wbRsp;

	// One VRAM access
	typedef struct packed {
		logic               en;
		logic               we;
		logic [VRAM_AW-1:0] addr;
		logic [15:0]        data;
	} vramCmd;

	// Register file to timer
	typedef struct packed {
		logic [31:0] reload;
		logic        lowWritten;
		logic        irqAck;
		logic [2:0]  mode;
		logic        irqEn;
		logic        stop;
	} timerCtrl;

endpackage

//--- hdl/lspcRegs.sv
/*
 * CPU register file
 * Wishbone classic slave, address decode, register storage
 * Read data select, VRAM read latch, VRAM write-request flag
 */
`timescale 1ns/1ns

module lspcRegs
	import lspcPkg::*;
(
	input  logic        clk24m,
	input  logic        rst,
	input  wbReq        bus,
	output wbRsp        busRsp,
	input  logic        busy,
	input  logic        stepAddr,
	input  logic [15:0] nextAddr,
	input  logic        latchLoad,
	input  logic [15:0] latchData,
	output logic        writeReq,
	output logic        prefetchOnly,
	output logic [15:0] vramAddr,
	output logic [15:0] vramMod,
	output logic [15:0] vramData,
	output timerCtrl    timer
);

	logic        ackReg;
	logic [15:0] rdDat;
	logic [15:0] readLatch;
	logic [15:0] readMux;
	// Mode bits 15:3 (AA speed, timer mode, IRQ enable, AA disable)
	logic [12:0] modeFields;
	logic [15:0] timerHigh;
	logic [15:0] timerLow;
	logic        timerStop;
	logic        writeFlag;
	logic        lowStrobe;
	logic        ackStrobe;
	logic        access;
	logic        holdOff;
	logic        accept;

	// New cycle, not the one just acked
	assign access = bus.cyc & bus.stb & ~ackReg;
	// VRAM ports wait for a pending or running access
	assign holdOff = (busy | writeFlag) &
		(bus.adr == REG_VRAMADDR || bus.adr == REG_VRAMRW);
	assign accept = access & ~holdOff;

	// Read data select
	always_comb
	begin
		case (bus.adr)
			REG_VRAMADDR, REG_VRAMRW: readMux = readLatch;
			REG_VRAMMOD:              readMux = vramMod;
			REG_LSPCMODE:             readMux = {modeFields, 3'b000};
			default:                  readMux = 16'h0000;
		endcase
	end

	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			ackReg       <= 1'b0;
			writeReq     <= 1'b0;
			prefetchOnly <= 1'b0;
			writeFlag    <= 1'b0;
			lowStrobe    <= 1'b0;
			ackStrobe    <= 1'b0;
			vramAddr     <= 16'h0000;
			vramMod      <= 16'h0000;
			vramData     <= 16'h0000;
			readLatch    <= 16'h0000;
			modeFields   <= '0;
			timerHigh    <= 16'h0000;
			timerLow     <= 16'h0000;
			timerStop    <= 1'b0;
		end
		else
		begin
			ackReg    <= accept;
			// Strobes last one cycle
			writeReq  <= 1'b0;
			lowStrobe <= 1'b0;
			ackStrobe <= 1'b0;
			// Address stepped by the FSM after a write
			if (stepAddr)
			begin
				vramAddr  <= nextAddr;
				writeFlag <= 1'b0;
			end
			if (latchLoad)
				readLatch <= latchData;
			if (accept & bus.we)
			begin
				case (bus.adr)
					REG_VRAMADDR:
					begin
						// New address, fetch it into the latch
						vramAddr     <= bus.dat;
						writeFlag    <= 1'b0;
						writeReq     <= 1'b1;
						prefetchOnly <= 1'b1;
					end
					REG_VRAMRW:
					begin
						vramData     <= bus.dat;
						writeFlag    <= 1'b1;
						writeReq     <= 1'b1;
						prefetchOnly <= 1'b0;
					end
					REG_VRAMMOD:   vramMod <= bus.dat;
					REG_LSPCMODE:  modeFields <= bus.dat[15:3];
					REG_TIMERHIGH: timerHigh <= bus.dat;
					REG_TIMERLOW:
					begin
						timerLow  <= bus.dat;
						lowStrobe <= 1'b1;
					end
					REG_IRQACK:    ackStrobe <= 1'b1;
					default:       timerStop <= bus.dat[0];
				endcase
			end
		end
	end

	// Read word captured on accept
	always_ff @(posedge clk24m)
	begin
		if (accept & ~bus.we)
			rdDat <= readMux;
	end

	assign busRsp = '{ack: ackReg, dat: rdDat};

	// Timer fields from mode bits 7:4
	assign timer = '{
		reload:     {timerHigh, timerLow},
		lowWritten: lowStrobe,
		irqAck:     ackStrobe,
		mode:       modeFields[4:2],
		irqEn:      modeFields[1],
		stop:       timerStop
	};

	// Master must hold the strobe until it sees ack
	ackNeedsStb: assert property (@(posedge clk24m) disable iff (rst)
		ackReg |-> bus.cyc && bus.stb)
		else $error("ack high without cyc and stb");

endmodule

//--- hdl/vramAccessFsm.sv
/*
 * VRAM access FSM
 * Runs queued CPU writes, steps the address by the modulo
 * Prefetches the word at the new address for the read latch
 */
`timescale 1ns/1ns

module vramAccessFsm
	import lspcPkg::*;
(
	input  logic        clk24m,
	input  logic        rst,
	input  logic        writeReq,
	input  logic        prefetchOnly,
	input  logic [15:0] vramAddr,
	input  logic [15:0] vramMod,
	input  logic [15:0] vramData,
	input  logic [15:0] rdData,
	output vramCmd      mem,
	output logic        busy,
	output logic        stepAddr,
	output logic [15:0] nextAddr,
	output logic        latchLoad,
	output logic [15:0] latchData
);

	typedef enum logic [1:0] {sIdle, sWrite, sFetch, sLatch} accessState;

	accessState  state;
	logic [15:0] addrReg;
	logic [15:0] modReg;
	logic [15:0] dataReg;

	// Sequence control
	always_ff @(posedge clk24m)
	begin
		if (rst)
			state <= sIdle;
		else
		begin
			case (state)
				sIdle:
				begin
					if (writeReq)
						state <= prefetchOnly ? sFetch : sWrite;
				end
				sWrite:  state <= sFetch;
				sFetch:  state <= sLatch;
				default: state <= sIdle;
			endcase
		end
	end

	// Request captured, modulo may change while busy
	always_ff @(posedge clk24m)
	begin
		if (state == sIdle && writeReq)
		begin
			addrReg <= vramAddr;
			modReg  <= vramMod;
			dataReg <= vramData;
		end
		else if (state == sWrite)
			addrReg <= nextAddr;
	end

	// Wraps at 16 bits
	assign nextAddr = addrReg + modReg;

	assign busy      = (state != sIdle);
	assign stepAddr  = (state == sWrite);
	assign latchLoad = (state == sLatch);
	// Read word arrives in the latch cycle
	assign latchData = rdData;

	// Write in sWrite, read of the stepped address in sFetch
	assign mem = '{
		en:   (state == sWrite) || (state == sFetch),
		we:   (state == sWrite),
		addr: addrReg[VRAM_AW-1:0],
		data: dataReg
	};

	// Queued request only while idle, otherwise it would be lost
	requestWhileIdle: assert property (@(posedge clk24m) disable iff (rst)
		writeReq |-> state == sIdle)
		else $error("VRAM request arrived while the access FSM was busy");

endmodule

//--- hdl/lspcTimer.sv
/*
 * Programmable interval timer
 * 32-bit down counter with load, reload at zero and stop
 * Interrupt flag with enable and acknowledge
 */
`timescale 1ns/1ns

module lspcTimer
	import lspcPkg::*;
(
	input  logic     clk24m,
	input  logic     rst,
	input  timerCtrl ctrl,
	output logic     timerIrq
);

	logic [31:0] count;
	// Counter reached zero on the last edge
	logic        zeroHit;
	logic        loadNow;
	logic        counting;

	// Load on a timer-low write, mode bit 0
	assign loadNow = ctrl.lowWritten & ctrl.mode[0];

	// Stops at zero until reloaded
	assign counting = ~ctrl.stop & (count != 32'd0);

	always_ff @(posedge clk24m)
	begin
		if (rst)
		begin
			count    <= 32'd0;
			zeroHit  <= 1'b0;
			timerIrq <= 1'b0;
		end
		else
		begin
			// Last step 1 to 0
			zeroHit <= ~loadNow & counting & (count == 32'd1);

			// CPU load wins over reload and count
			if (loadNow)
				count <= ctrl.reload;
			else if (zeroHit & ctrl.mode[1])
				count <= ctrl.reload;
			else if (counting)
				count <= count - 32'd1;

			// Ack clears, a new zero event wins
			if (ctrl.irqAck)
				timerIrq <= 1'b0;
			if (zeroHit & ctrl.irqEn)
				timerIrq <= 1'b1;
		end
	end

	// Last count step with IRQ enabled raises the flag one cycle later
	irqAfterZero: assert property (@(posedge clk24m) disable iff (rst)
		counting && !loadNow && count == 32'd1 ##1 ctrl.irqEn |=> timerIrq)
		else $error("timer IRQ missing after the count reached zero");

endmodule

//--- hdl/vramMem.sv
/*
 * Single-port synchronous VRAM
 * VRAM_DEPTH words of 16 bits
 * Registered read, one cycle latency
 */
`timescale 1ns/1ns

module vramMem
	import lspcPkg::*;
(
	input  logic        clk24m,
	input  vramCmd      cmd,
	output logic [15:0] rdData
);

	// Storage array
	logic [15:0] words [VRAM_DEPTH];

	// Write or read, never both in one cycle
	always_ff @(posedge clk24m)
	begin
		if (cmd.en)
		begin
			if (cmd.we)
				words[cmd.addr] <= cmd.data;
			else
				rdData <= words[cmd.addr];
		end
	end

endmodule

//--- hdl/lspcTop.sv
/*
 * Register subsystem top level
 * Register file, VRAM access FSM, timer, VRAM
 */
`timescale 1ns/1ns

module lspcTop
	import lspcPkg::*;
(
	input  logic clk24m,
	input  logic rst,
	input  wbReq bus,
	output wbRsp busRsp,
	output logic timerIrq
);

	// Register file to FSM
	logic        writeReq;
	logic        prefetchOnly;
	logic [15:0] vramAddr;
	logic [15:0] vramMod;
	logic [15:0] vramData;
	// FSM back to register file
	logic        busy;
	logic        stepAddr;
	logic [15:0] nextAddr;
	logic        latchLoad;
	logic [15:0] latchData;
	// VRAM side
	vramCmd      memCmd;
	logic [15:0] rdData;
	timerCtrl    timer;

	lspcRegs uRegs (
		.clk24m       (clk24m),
		.rst          (rst),
		.bus          (bus),
		.busRsp       (busRsp),
		.busy         (busy),
		.stepAddr     (stepAddr),
		.nextAddr     (nextAddr),
		.latchLoad    (latchLoad),
		.latchData    (latchData),
		.writeReq     (writeReq),
		.prefetchOnly (prefetchOnly),
		.vramAddr     (vramAddr),
		.vramMod      (vramMod),
		.vramData     (vramData),
		.timer        (timer)
	);

	vramAccessFsm uFsm (
		.clk24m       (clk24m),
		.rst          (rst),
		.writeReq     (writeReq),
		.prefetchOnly (prefetchOnly),
		.vramAddr     (vramAddr),
		.vramMod      (vramMod),
		.vramData     (vramData),
		.rdData       (rdData),
		.mem          (memCmd),
		.busy         (busy),
		.stepAddr     (stepAddr),
		.nextAddr     (nextAddr),
		.latchLoad    (latchLoad),
		.latchData    (latchData)
	);

	lspcTimer uTimer (
		.clk24m   (clk24m),
		.rst      (rst),
		.ctrl     (timer),
		.timerIrq (timerIrq)
	);

	vramMem uMem (
		.clk24m (clk24m),
		.cmd    (memCmd),
		.rdData (rdData)
	);

endmodule

//--- verification/tbLspc.sv
/*
 * Testbench for the register subsystem top level
 * Trace reader, Wishbone classic driver, shadow VRAM model
 * Value checker, timer IRQ watcher, watchdog and summary
 */
`timescale 1ns/1ns

module tbLspc
	import lspcPkg::*;
();

	localparam TRACE_FILE = "verification/lspcTrace.txt";
	// Longest held-off access stays well inside this
	localparam int ACK_LIMIT = 16;

	logic        clk24m = 1'b0;
	logic        rst;
	wbReq        bus;
	wbRsp        busRsp;
	logic        timerIrq;

	// Shadow VRAM and the CPU-visible registers behind it
	logic [15:0] shadow [VRAM_DEPTH];
	logic [15:0] tbAddr;
	logic [15:0] tbMod;
	logic [15:0] tbMode;

	int traceLines;
	int errorCount;
	int testErrors;
	int checkCount;
	int testsRun;
	int testsPassed;

	lspcTop u_dut (
		.clk24m   (clk24m),
		.rst      (rst),
		.bus      (bus),
		.busRsp   (busRsp),
		.timerIrq (timerIrq)
	);

	// 40 ns period
	always #20 clk24m = ~clk24m;

	task automatic checkValue(
		input string       name,
		input logic [15:0] got,
		input logic [15:0] expected
	);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			testErrors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		testErrors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// One Wishbone classic cycle, ends at the edge after ack
	task automatic busAccess(
		input  logic        write,
		input  logic [2:0]  offset,
		input  logic [15:0] wdata,
		output logic [15:0] rdata,
		output logic        acked
	);
		int waited;
		waited = 0;
		acked  = 1'b0;
		rdata  = 16'hxxxx;
		@(posedge clk24m);
		bus.cyc <= 1'b1;
		bus.stb <= 1'b1;
		bus.we  <= write;
		bus.adr <= offset;
		bus.dat <= wdata;
		// Ack sampled mid-cycle
		while (!acked && waited < ACK_LIMIT)
		begin
			@(negedge clk24m);
			if (busRsp.ack === 1'b1)
			begin
				acked = 1'b1;
				rdata = busRsp.dat;
			end
			else
				waited++;
		end
		@(posedge clk24m);
		bus <= '0;
		if (!acked)
			reportProblem($sformatf("no ack from register %0d within %0d cycles",
				offset, ACK_LIMIT));
	endtask

	// Register and VRAM effects of an acked write
	task automatic updateModel(input logic [2:0] offset, input logic [15:0] wdata);
		case (offset)
			REG_VRAMADDR: tbAddr = wdata;
			REG_VRAMRW:
			begin
				// Only the low address bits index VRAM
				shadow[tbAddr[VRAM_AW-1:0]] = wdata;
				tbAddr = tbAddr + tbMod;
			end
			REG_VRAMMOD:  tbMod = wdata;
			REG_LSPCMODE: tbMode = wdata;
			default:      ;
		endcase
	endtask

	// Expected read data from the register map
	function automatic logic [15:0] modelRead(input logic [2:0] offset);
		case (offset)
			// Latch holds the word at the current address
			REG_VRAMADDR, REG_VRAMRW: modelRead = shadow[tbAddr[VRAM_AW-1:0]];
			REG_VRAMMOD:              modelRead = tbMod;
			REG_LSPCMODE:             modelRead = tbMode & 16'hFFF8;
			default:                  modelRead = 16'h0000;
		endcase
	endfunction

	// Level 1 must appear in the window, level 0 must hold throughout
	task automatic watchIrq(input int level, input int window);
		int   cycles;
		logic stopEarly;
		stopEarly = 1'b0;
		for (cycles = 0; cycles < window && !stopEarly; cycles++)
		begin
			@(negedge clk24m);
			if (level == 1)
			begin
				if (timerIrq === 1'b1)
					stopEarly = 1'b1;
			end
			else if (timerIrq !== 1'b0)
			begin
				checkValue("timerIrq", {15'b0, timerIrq}, 16'h0000);
				stopEarly = 1'b1;
			end
		end
		if (level == 1 && !stopEarly)
			reportProblem($sformatf("timerIrq did not rise within %0d cycles", window));
	endtask

	task automatic finishTest(input logic [8*32-1:0] name);
		if (testErrors == 0)
		begin
			testsPassed++;
			$display("test %0s passed", name);
		end
		else
			$display("test %0s failed with %0d errors", name, testErrors);
	endtask

	initial
	begin : runTrace
		int               fd;
		int               n;
		int               level;
		int               window;
		int               lineCount;
		logic [8*32-1:0]  token;
		logic [8*32-1:0]  testName;
		logic [8*128-1:0] lineBuf;
		logic [15:0]      argA;
		logic [15:0]      argB;
		logic [15:0]      rd;
		logic             acked;
		logic             done;
		rst         <= 1'b1;
		bus         <= '0;
		errorCount  = 0;
		testErrors  = 0;
		checkCount  = 0;
		testsRun    = 0;
		testsPassed = 0;
		lineCount   = 0;
		tbAddr      = 16'h0000;
		tbMod       = 16'h0000;
		tbMode      = 16'h0000;
		testName    = "none";

		// Line count arms the watchdog
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
			reportProblem("cannot open the trace file");
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(lineBuf, fd);
				if (n > 0)
					lineCount++;
			end
			$fclose(fd);
			traceLines = lineCount;
			fd = $fopen(TRACE_FILE, "r");
		end

		repeat (8) @(posedge clk24m);
		rst <= 1'b0;

		done = (fd == 0);
		while (!done)
		begin
			n = $fscanf(fd, "%s", token);
			if (n != 1)
				done = 1'b1;
			else if (token == "#")
				n = $fgets(lineBuf, fd);
			else if (token == "T")
			begin
				n = $fscanf(fd, "%s", testName);
				testErrors = 0;
				testsRun++;
			end
			else if (token == "W")
			begin
				n = $fscanf(fd, "%h %h", argA, argB);
				busAccess(1'b1, argA[2:0], argB, rd, acked);
				if (acked)
					updateModel(argA[2:0], argB);
			end
			else if (token == "R")
			begin
				n = $fscanf(fd, "%h %h", argA, argB);
				// Trace value against the shadow
				checkValue("shadow model", modelRead(argA[2:0]), argB);
				busAccess(1'b0, argA[2:0], 16'h0000, rd, acked);
				if (acked)
					checkValue($sformatf("busRsp.dat at offset %0d", argA[2:0]), rd, argB);
			end
			else if (token == "Q")
			begin
				n = $fscanf(fd, "%d %d", level, window);
				watchIrq(level, window);
			end
			else if (token == "E")
				finishTest(testName);
			else
				reportProblem($sformatf("unknown trace command %0s", token));
		end
		if (fd != 0)
			$fclose(fd);

		$display("%0d tests run, %0d passed, %0d failed, %0d checks, %0d errors",
			testsRun, testsPassed, testsRun - testsPassed, checkCount, errorCount);
		if (errorCount == 0 && testsRun > 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// 64 cycles per trace line
	initial
	begin
		wait (traceLines > 0);
		#(traceLines * 64 * 40);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			traceLines * 64);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verification/lspcTrace.txt
# Columns: command, then arguments. T name | W offset data | R offset expected | E
# Q level window: timerIrq level 0 or 1, window in cycles (decimal); other numbers hex
T resetState
R 2 0000
R 3 0000
Q 0 4
E
T regReadback
W 2 1234
R 2 1234
W 2 a5c3
R 2 a5c3
W 3 ffff
R 3 fff8
W 3 0008
R 3 0008
W 3 0000
R 3 0000
W 4 5678
R 4 0000
R 5 0000
R 6 0000
R 7 0000
E
T vramIncrement
W 2 0001
W 0 0100
W 1 1111
W 1 2222
W 1 3333
W 1 4444
W 0 0100
R 1 1111
W 0 0101
R 1 2222
R 0 2222
W 0 0102
R 1 3333
W 0 0103
R 1 4444
E
T moduloWrap
W 2 ffff
W 0 0002
W 1 aaaa
W 1 bbbb
W 1 cccc
W 1 dddd
W 0 0002
R 1 aaaa
W 0 0001
R 1 bbbb
W 0 0000
R 1 cccc
W 0 07ff
R 1 dddd
W 2 0800
W 0 0005
W 1 5555
R 1 5555
W 1 6666
W 0 f805
R 1 6666
E
T timerIrq
W 4 0000
W 3 0070
W 5 000a
Q 1 14
W 6 0000
Q 0 3
Q 1 14
W 3 0060
W 6 0000
Q 0 30
E
T timerStop
W 7 0001
W 3 0070
W 5 000a
Q 0 30
W 7 0000
Q 1 14
W 6 0000
E

//--- src.f
hdl/lspcPkg.sv
hdl/lspcRegs.sv
hdl/vramAccessFsm.sv
hdl/lspcTimer.sv
hdl/vramMem.sv
hdl/lspcTop.sv
verification/tbLspc.sv
